// File: hw/ex_alu.sv
/*
 * Single-cycle ALU for RV64I register and immediate operations,
 * including the W forms, link and upper-immediate values and
 * the load/store address.
 */
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  ex_op_t op_i,
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    input  imm12_t ls_offset_i,
    output xlen_t  result_o,
    output xlen_t  mem_addr_o
);

    shamt_t     shamt;
    logic [4:0] shamt_w;
    xlen_t      upper_imm;
    xlen_t      offset_ext;
    word_t      addw_res;
    word_t      subw_res;
    word_t      sllw_res;
    word_t      srlw_res;
    word_t      sraw_res;

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];

    // lui/auipc immediate sits in op2[19:0]
    assign upper_imm  = {{(XLEN-32){op2_i[19]}}, op2_i[19:0], 12'd0};
    assign offset_ext = {{(XLEN-12){ls_offset_i[11]}}, ls_offset_i};

    assign addw_res = op1_i[WLEN-1:0] + op2_i[WLEN-1:0];
    assign subw_res = op1_i[WLEN-1:0] - op2_i[WLEN-1:0];
    assign sllw_res = op1_i[WLEN-1:0] << shamt_w;
    assign srlw_res = op1_i[WLEN-1:0] >> shamt_w;
    assign sraw_res = $signed(op1_i[WLEN-1:0]) >>> shamt_w;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = op1_i + op2_i;
            end
            OP_SUB: begin
                result_o = op1_i - op2_i;
            end
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            end
            OP_XOR:   result_o = op1_i ^ op2_i;
            OP_OR:    result_o = op1_i | op2_i;
            OP_AND:   result_o = op1_i & op2_i;
            OP_SLL:   result_o = op1_i << shamt;
            OP_SRL:   result_o = op1_i >> shamt;
            OP_SRA:   result_o = $signed(op1_i) >>> shamt;
            OP_ADDW:  result_o = sext_w(addw_res);
            OP_SUBW:  result_o = sext_w(subw_res);
            OP_SLLW:  result_o = sext_w(sllw_res);
            OP_SRLW:  result_o = sext_w(srlw_res);
            OP_SRAW:  result_o = sext_w(sraw_res);
            // op1 is zero for lui and the pc for auipc
            OP_UPPER: result_o = op1_i + upper_imm;
            // op2 carries the pc of the jump
            OP_LINK:  result_o = op2_i + 64'd4;
            default:  result_o = '0;
        endcase
    end

    assign mem_addr_o = (op_i == OP_MEM) ? op1_i + offset_ext : '0;

endmodule

// File: hw/ex_branch.sv
/*
 * Branch resolution.
 * The front end predicts every branch taken, so a redirect to
 * pc + 4 is raised only when the condition turns out false.
 */
`timescale 1ns/1ps

module ex_branch import ex_pkg::*; (
    input  ex_op_t op_i,
    input  xlen_t  pc_i,
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    output logic   redirect_o,
    output xlen_t  redirect_pc_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (op1_i == op2_i);
    assign lt_s = ($signed(op1_i) < $signed(op2_i));
    assign lt_u = (op1_i < op2_i);

    always_comb begin
        case (op_i)
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = !eq;
            OP_BLT:  cond = lt_s;
            OP_BGE:  cond = !lt_s;
            OP_BLTU: cond = lt_u;
            OP_BGEU: cond = !lt_u;
            default: cond = 1'b1;
        endcase
    end

    // mispredict when not taken
    assign redirect_o    = is_branch_op(op_i) && !cond;
    assign redirect_pc_o = redirect_o ? pc_i + 64'd4 : '0;

endmodule

// File: hw/ex_multiplier.sv
/*
 * Iterative shift-add multiplier for MUL, MULH, MULHSU, MULHU and MULW.
 * Works on operand magnitudes, one bit per cycle, and holds the
 * pipeline through a stall request until the product is ready.
 */
`timescale 1ns/1ps

module ex_multiplier import ex_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  ex_op_t op_i,
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    output xlen_t  product_o,
    output logic   stall_req_o
);

    localparam int CNT_W = $clog2(XLEN);

    mul_state_t        state_q;
    logic [CNT_W-1:0]  count_q;
    logic [2*XLEN-1:0] acc_q;
    xlen_t             mcand_q;
    logic              neg_q;
    logic              hi_q;
    logic              w_q;
    logic              start;
    logic              op1_neg;
    logic              op2_neg;
    xlen_t             op1_mag;
    xlen_t             op2_mag;
    logic [XLEN:0]     step_sum;
    logic [2*XLEN-1:0] full_prod;

    assign start = (state_q == IDLE) && is_mul_op(op_i);

    // signedness per operation; mulw only needs the low word,
    // which is the same for signed and unsigned operands
    assign op1_neg = (op_i inside {OP_MUL, OP_MULH, OP_MULHSU}) && op1_i[XLEN-1];
    assign op2_neg = (op_i inside {OP_MUL, OP_MULH}) && op2_i[XLEN-1];
    assign op1_mag = op1_neg ? -op1_i : op1_i;
    assign op2_mag = op2_neg ? -op2_i : op2_i;

    // upper half gains the multiplicand when the current bit is set
    assign step_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    count_q <= '0;
                    if (start) begin
                        state_q <= BUSY;
                    end
                end
                BUSY: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(XLEN - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_q   <= {{XLEN{1'b0}}, op2_mag};
            mcand_q <= op1_mag;
            neg_q   <= op1_neg ^ op2_neg;
            hi_q    <= (op_i inside {OP_MULH, OP_MULHSU, OP_MULHU});
            w_q     <= (op_i == OP_MULW);
        end else if (state_q == BUSY) begin
            acc_q <= {step_sum, acc_q[XLEN-1:1]};
        end
    end

    assign full_prod = neg_q ? -acc_q : acc_q;

    always_comb begin
        if (state_q != DONE) begin
            product_o = '0;
        end else if (w_q) begin
            product_o = sext_w(full_prod[WLEN-1:0]);
        end else if (hi_q) begin
            product_o = full_prod[2*XLEN-1:XLEN];
        end else begin
            product_o = full_prod[XLEN-1:0];
        end
    end

    // high from acceptance through BUSY, low in DONE
    assign stall_req_o = is_mul_op(op_i) && (state_q != DONE);

endmodule

// File: hw/ex_pkg.sv
/*
 * Execute stage package for the RV64 integer pipeline.
 * Holds the width types, the operation encoding and the class helpers.
 */
package ex_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [WLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [11:0]     imm12_t;
    typedef logic [5:0]      shamt_t;

    // immediate forms share the register entries, op2 carries the immediate
    typedef enum logic [4:0] {
        OP_NONE, OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA, OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_UPPER, OP_LINK, OP_MEM,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW
    } ex_op_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mul_state_t;

    function automatic logic is_mul_op(ex_op_t op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
    endfunction

    function automatic logic is_branch_op(ex_op_t op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    // W-form results are widened by sign extension of bit 31
    function automatic xlen_t sext_w(word_t w);
        return {{(XLEN-WLEN){w[WLEN-1]}}, w};
    endfunction

endpackage

// File: hw/ex_stage.sv
/*
 * RV64 execute stage.
 * Combines the ALU, the branch unit and the iterative multiplier,
 * and picks the writeback value by operation class.
 */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  xlen_t  pc_i,
    input  ex_op_t op_i,
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    input  imm12_t ls_offset_i,
    output xlen_t  rd_data_o,
    output xlen_t  ls_addr_o,
    output logic   redirect_o,
    output xlen_t  redirect_pc_o,
    output logic   stall_req_o
);

    xlen_t alu_result;
    xlen_t mul_product;

    ex_alu u_alu (
        .op_i        (op_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .ls_offset_i (ls_offset_i),
        .result_o    (alu_result),
        .mem_addr_o  (ls_addr_o)
    );

    ex_branch u_branch (
        .op_i          (op_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    ex_multiplier u_mul (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_i        (op_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .product_o   (mul_product),
        .stall_req_o (stall_req_o)
    );

    // product is only meaningful in the multiplier's DONE cycle,
    // which is also the cycle where the stall drops
    assign rd_data_o = is_mul_op(op_i) ? mul_product : alu_result;

endmodule

// File: list.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_multiplier.sv
hw/ex_stage.sv
test/ex_stage_chk.sv
test/tb_ex_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f list.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_ex_stage; then
    echo "simulation failed"
    exit 1
fi

exit 0

// File: test/ex_stage_chk.sv
/*
 * Assertions on the execute stage stall request and redirect.
 */
`timescale 1ns/1ps

module ex_stage_chk import ex_pkg::*; (
    input logic   clk,
    input logic   reset_i,
    input ex_op_t op_i,
    input xlen_t  op1_i,
    input xlen_t  op2_i,
    input logic   stall_req_i,
    input logic   redirect_i
);

    int stall_run_q;

    // consecutive cycles with the stall request high
    always_ff @(posedge clk) begin
        if (reset_i || !stall_req_i) begin
            stall_run_q <= 0;
        end else begin
            stall_run_q <= stall_run_q + 1;
        end
    end

    stall_len: assert property (@(posedge clk) disable iff (reset_i)
        stall_run_q <= XLEN + 4)
        else $error("stall request held longer than the multiply latency");

    // a cycle without a stall leaves the multiplier idle
    stall_start: assert property (@(posedge clk) disable iff (reset_i)
        is_mul_op(op_i) && !$past(stall_req_i) |-> stall_req_i)
        else $error("multiply accepted without a stall request");

    // equal operands take beq, bge and bgeu, the others fall through
    redirect_equal: assert property (@(posedge clk) disable iff (reset_i)
        is_branch_op(op_i) && (op1_i == op2_i)
            |-> redirect_i == (op_i inside {OP_BNE, OP_BLT, OP_BLTU}))
        else $error("wrong redirect for a branch on equal operands");

endmodule

bind ex_stage ex_stage_chk u_chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .op_i        (op_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .stall_req_i (stall_req_o),
    .redirect_i  (redirect_o)
);

// File: test/tb_ex_stage.sv
/*
 * Directed testbench for the RV64 execute stage.
 * Covers the ALU, address generation, branches, the multiplier and reset.
 */
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    logic   clk;
    logic   reset_i;
    xlen_t  pc_i;
    ex_op_t op_i;
    xlen_t  op1_i;
    xlen_t  op2_i;
    imm12_t ls_offset_i;
    xlen_t  rd_data_o;
    xlen_t  ls_addr_o;
    logic   redirect_o;
    xlen_t  redirect_pc_o;
    logic   stall_req_o;
    int     seed = 32'h4533ae7b;

    ex_stage u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (pc_i),
        .op_i          (op_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .ls_offset_i   (ls_offset_i),
        .rd_data_o     (rd_data_o),
        .ls_addr_o     (ls_addr_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .stall_req_o   (stall_req_o)
    );

    always #4 clk = ~clk;

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xlen_t alu_model(ex_op_t op, xlen_t a, xlen_t b);
        word_t w;
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU:  return (a < b) ? 64'd1 : 64'd0;
            OP_XOR:   return a ^ b;
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_SLL:   return a << b[5:0];
            OP_SRL:   return a >> b[5:0];
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_ADDW:  w = a[31:0] + b[31:0];
            OP_SUBW:  w = a[31:0] - b[31:0];
            OP_SLLW:  w = a[31:0] << b[4:0];
            OP_SRLW:  w = a[31:0] >> b[4:0];
            OP_SRAW:  w = $signed(a[31:0]) >>> b[4:0];
            OP_UPPER: return a + {{32{b[19]}}, b[19:0], 12'h000};
            OP_LINK:  return b + 64'd4;
            default:  return 64'd0;
        endcase
        // only the W forms fall through to here
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic branch_taken(ex_op_t op, xlen_t a, xlen_t b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic xlen_t mul_model(ex_op_t op, xlen_t a, xlen_t b);
        logic [127:0] p;
        case (op)
            OP_MULH:   p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
            OP_MULHSU: p = {{64{a[63]}}, a} * {64'd0, b};
            default:   p = {64'd0, a} * {64'd0, b};
        endcase
        if (op == OP_MULW) begin
            return {{32{p[31]}}, p[31:0]};
        end else if (op == OP_MUL) begin
            return p[63:0];
        end
        return p[127:64];
    endfunction

    task automatic check_xlen(string test, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(string test, logic exp, logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", test, exp, act);
            $display("Done: errors found");
            $fatal(1, "flag mismatch");
        end
    endtask

    // inputs change on the falling edge, outputs are sampled 1 ns later
    task automatic present_op(ex_op_t op, xlen_t pc, xlen_t a, xlen_t b, imm12_t off);
        @(negedge clk);
        op_i = op;
        pc_i = pc;
        op1_i = a;
        op2_i = b;
        ls_offset_i = off;
        #1;
    endtask

    task automatic check_alu(string test, ex_op_t op, xlen_t a, xlen_t b);
        present_op(op, 64'd0, a, b, 12'd0);
        check_xlen({test, " ", op.name()}, alu_model(op, a, b), rd_data_o);
        check_xlen({test, " addr"}, 64'd0, ls_addr_o);
        check_bit({test, " stall"}, 1'b0, stall_req_o);
        check_bit({test, " redirect"}, 1'b0, redirect_o);
    endtask

    task automatic run_mul(string test, ex_op_t op, xlen_t a, xlen_t b);
        int n;
        present_op(op, 64'd0, a, b, 12'd0);
        check_bit({test, " stall"}, 1'b1, stall_req_o);
        n = 0;
        while (stall_req_o) begin
            if (n == XLEN + 8) begin
                $display("timeout: stall request for %s never dropped", op.name());
                $display("Done: errors found");
                $fatal(1, "multiplier timeout");
            end
            @(negedge clk);
            #1;
            n++;
        end
        check_xlen({test, " ", op.name()}, mul_model(op, a, b), rd_data_o);
        // next operation is accepted only if the FSM is back in IDLE
        check_alu({test, " follow"}, OP_ADD, a, b);
    endtask

    task automatic test_logic_arith();
        ex_op_t ops[7] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND};
        xlen_t  corners[4] = '{64'd0, '1, 64'h8000_0000_0000_0000, 64'd1};
        foreach (ops[i]) begin
            foreach (corners[j]) begin
                foreach (corners[k]) begin
                    check_alu("arith", ops[i], corners[j], corners[k]);
                end
            end
            repeat (8) begin
                check_alu("arith rand", ops[i], rand64(), rand64());
            end
        end
    endtask

    task automatic test_shifts_w();
        ex_op_t ops[6] = '{OP_SLL, OP_SRL, OP_SRA, OP_SLLW, OP_SRLW, OP_SRAW};
        shamt_t amts[5] = '{6'd0, 6'd1, 6'd31, 6'd32, 6'd63};
        xlen_t  a;
        xlen_t  b;
        foreach (ops[i]) begin
            foreach (amts[j]) begin
                a = rand64() | 64'h8000_0000_8000_0000;
                b = rand64();
                b[5:0] = amts[j];
                check_alu("shift", ops[i], a, b);
            end
        end
        repeat (8) begin
            a = rand64() | 64'h0000_0000_8000_0000;
            b = rand64() | 64'h0000_0000_8000_0000;
            check_alu("addw", OP_ADDW, a, b);
            check_alu("subw", OP_SUBW, a, b);
        end
    endtask

    task automatic test_upper_link_mem();
        xlen_t  a;
        xlen_t  b;
        xlen_t  r;
        imm12_t off;
        repeat (8) begin
            a = rand64();
            b = rand64();
            r = rand64();
            check_alu("upper", OP_UPPER, a, b);
            check_alu("link", OP_LINK, a, b);
            off = {1'b1, r[10:0]};
            present_op(OP_MEM, 64'd0, a, b, off);
            check_xlen("mem addr", a + {{52{off[11]}}, off}, ls_addr_o);
            check_bit("mem stall", 1'b0, stall_req_o);
        end
    endtask

    task automatic test_branches();
        ex_op_t br_ops[6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        xlen_t  pa[3] = '{64'd5, '1, 64'd1};
        xlen_t  pb[3] = '{64'd5, 64'd1, '1};
        xlen_t  pc;
        logic   cond;
        foreach (br_ops[i]) begin
            foreach (pa[j]) begin
                pc = rand64();
                pc[1:0] = 2'b00;
                cond = branch_taken(br_ops[i], pa[j], pb[j]);
                present_op(br_ops[i], pc, pa[j], pb[j], 12'd0);
                check_bit({"branch ", br_ops[i].name()}, !cond, redirect_o);
                check_xlen({"branch pc ", br_ops[i].name()},
                    cond ? 64'd0 : pc + 64'd4, redirect_pc_o);
            end
        end
        check_alu("branch add", OP_ADD, 64'd5, 64'd5);
    endtask

    task automatic test_multiplier();
        ex_op_t mul_ops[5] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
        foreach (mul_ops[i]) begin
            run_mul("mul pos", mul_ops[i], rand64() & 64'h7fff_ffff_ffff_ffff,
                rand64() & 64'h7fff_ffff_ffff_ffff);
            run_mul("mul neg", mul_ops[i], rand64() | 64'h8000_0000_0000_0000,
                rand64() | 64'h8000_0000_0000_0000);
            run_mul("mul mixed", mul_ops[i], rand64() | 64'h8000_0000_0000_0000,
                rand64() & 64'h7fff_ffff_ffff_ffff);
        end
    endtask

    task automatic test_reset();
        xlen_t a;
        xlen_t b;
        a = rand64();
        b = rand64();
        present_op(OP_MULHU, 64'd0, a, b, 12'd0);
        repeat (5) @(negedge clk);
        check_bit("reset busy", 1'b1, stall_req_o);
        reset_i = 1'b1;
        op_i = OP_NONE;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        check_alu("reset add", OP_ADD, a, b);
        // a fresh multiply only comes out right from a cleared FSM
        run_mul("reset mul", OP_MUL, rand64(), rand64());
    endtask

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        pc_i = '0;
        op_i = OP_NONE;
        op1_i = '0;
        op2_i = '0;
        ls_offset_i = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        test_logic_arith();
        test_shifts_w();
        test_upper_link_mem();
        test_branches();
        test_multiplier();
        test_reset();
        $display("Done: no errors");
        $finish;
    end

endmodule
